// File: Makefile
TOP = uart_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir -o sim_uart
	./obj_dir/sim_uart | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

// File: flist.f
uart_reg_pkg.sv
uart_line_pkg.sv
uart_tx.sv
uart_rx.sv
rx_fifo.sv
uart.sv
uart_tb.sv

// File: rx_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module rx_fifo
#(
   parameter int depth_log2 = 4
)
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  wr,
   input  logic [7:0]            w_data,
   input  logic                  rd,
   output logic [7:0]            r_data,
   output logic                  empty,
   output logic                  full,
   output logic [depth_log2:0]   level
);

   localparam int depth = 1 << depth_log2;

   logic [7:0]            mem [depth];
   logic [depth_log2-1:0] w_ptr;
   logic [depth_log2-1:0] r_ptr;
   logic                  do_wr;
   logic                  do_rd;

   assign empty  = (level == '0);
   assign full   = (level == (depth_log2 + 1)'(depth));
   assign do_wr  = wr && !full;    // Overflow is dropped here
   assign do_rd  = rd && !empty;
   assign r_data = mem[r_ptr];     // Head word, visible before the pop

   always_ff @(posedge clk)
   begin
      if (do_wr)
         mem[w_ptr] <= w_data;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         w_ptr <= '0;
         r_ptr <= '0;
         level <= '0;
      end
      else
      begin
         if (do_wr)
            w_ptr <= w_ptr + 1'b1;  // Pointers wrap naturally
         if (do_rd)
            r_ptr <= r_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   level <= level + 1'b1;
            2'b01:   level <= level - 1'b1;
            default: level <= level;
         endcase
      end
   end

   a_level_bound: assert property (@(posedge clk) disable iff (reset)
      level <= (depth_log2 + 1)'(depth));

   a_ignored_stable: assert property (@(posedge clk) disable iff (reset)
      ((wr && full && !rd) || (rd && empty && !wr)) |=> $stable(level));

endmodule

`default_nettype wire

// File: uart.sv
`timescale 1ns/1ns
`default_nettype none

module uart
(
   input  logic                               clk,
   input  logic                               reset,
   input  logic                               cs,
   input  logic                               wen,
   input  logic [3:0]                         addr,
   input  logic [uart_reg_pkg::bus_width-1:0] din,
   output logic [uart_reg_pkg::bus_width-1:0] dout,
   input  logic                               rxd,
   output logic                               txd
);

   localparam int bw = uart_reg_pkg::bus_width;
   localparam int lw = uart_reg_pkg::fifo_depth_log2 + 1;

   uart_reg_pkg::reg_addr_e reg_sel;

   logic                                      bus_wr;
   logic                                      bus_rd;
   logic [1:0]                                ctrl;
   logic [uart_line_pkg::cpb_width-1:0]       cpb;
   logic [bw-1:0]                             scratch [4];
   logic                                      break_flag;

   logic                                      tx_valid;
   logic [uart_line_pkg::data_bits-1:0]       tx_data;
   logic                                      tx_ready;

   logic                                      rx_valid;
   logic [uart_line_pkg::data_bits-1:0]       rx_data;
   logic                                      rx_break;
   logic [31:0]                               char_count;

   logic                                      fifo_rd;
   logic [7:0]                                fifo_head;
   logic                                      fifo_empty;
   logic                                      fifo_full;
   logic [lw-1:0]                             fifo_level;
   logic [31:0]                               fifo_wr_count;
   logic [31:0]                               fifo_full_count;

   logic [bw-1:0]                             rstat;
   logic [bw-1:0]                             tstat;

   assign reg_sel = uart_reg_pkg::reg_addr_e'(addr);
   assign bus_wr  = cs && wen;
   assign bus_rd  = cs && !wen;

   // Byte goes to the transmitter only when TX is enabled
   assign tx_valid = bus_wr && (reg_sel == uart_reg_pkg::reg_dr) &&
                     ctrl[uart_reg_pkg::ctrl_tx_en];
   assign tx_data  = din[uart_line_pkg::data_bits-1:0];
   assign fifo_rd  = bus_rd && (reg_sel == uart_reg_pkg::reg_queue);

   // Control state
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ctrl       <= '0;
         cpb        <= uart_line_pkg::cpb_default;
         break_flag <= 1'b0;
      end
      else
      begin
         if (bus_wr && reg_sel == uart_reg_pkg::reg_ctrl)
            ctrl <= din[1:0];
         if (bus_wr && reg_sel == uart_reg_pkg::reg_cpb)
            cpb <= din[uart_line_pkg::cpb_width-1:0];
         if (rx_break)
            break_flag <= 1'b1;  // A new break beats a clear
         else if (bus_wr && reg_sel == uart_reg_pkg::reg_rstat)
            break_flag <= 1'b0;
      end
   end

   // Scratch registers at 12 to 15
   always_ff @(posedge clk)
   begin
      if (bus_wr && addr[3:2] == 2'b11)
         scratch[addr[1:0]] <= din;
   end

   // Every received character lands in exactly one of these
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         fifo_wr_count   <= '0;
         fifo_full_count <= '0;
      end
      else if (rx_valid)
      begin
         if (fifo_full)
            fifo_full_count <= fifo_full_count + 1'b1;
         else
            fifo_wr_count <= fifo_wr_count + 1'b1;
      end
   end

   always_comb
   begin
      rstat = '0;
      rstat[uart_reg_pkg::stat_rxne]                 = !fifo_empty;
      rstat[uart_reg_pkg::stat_break]                = break_flag;
      rstat[uart_reg_pkg::stat_full]                 = fifo_full;
      rstat[uart_reg_pkg::stat_level_lsb +: lw]      = fifo_level;
      tstat = '0;
      tstat[uart_reg_pkg::stat_tc]                   = tx_ready;
   end

   // Read mux, unmapped addresses give zero
   always_comb
   begin
      case (reg_sel)
         uart_reg_pkg::reg_dr,
         uart_reg_pkg::reg_queue:           dout = bw'(fifo_head);
         uart_reg_pkg::reg_ctrl:            dout = bw'(ctrl);
         uart_reg_pkg::reg_rstat:           dout = rstat;
         uart_reg_pkg::reg_tstat:           dout = tstat;
         uart_reg_pkg::reg_cpb:             dout = bw'(cpb);
         uart_reg_pkg::reg_char_count:      dout = char_count;
         uart_reg_pkg::reg_fifo_wr_count:   dout = fifo_wr_count;
         uart_reg_pkg::reg_fifo_full_count: dout = fifo_full_count;
         uart_reg_pkg::reg_scratch0,
         uart_reg_pkg::reg_scratch1,
         uart_reg_pkg::reg_scratch2,
         uart_reg_pkg::reg_scratch3:        dout = scratch[addr[1:0]];
         default:                           dout = '0;
      endcase
   end

   uart_tx tx_i
   (
      .clk      (clk),
      .reset    (reset),
      .cpb      (cpb),
      .tx_valid (tx_valid),
      .tx_data  (tx_data),
      .tx_ready (tx_ready),
      .txd      (txd)
   );

   uart_rx rx_i
   (
      .clk        (clk),
      .reset      (reset),
      .cpb        (cpb),
      .rx_en      (ctrl[uart_reg_pkg::ctrl_rx_en]),
      .rxd        (rxd),
      .rx_valid   (rx_valid),
      .rx_data    (rx_data),
      .rx_break   (rx_break),
      .char_count (char_count)
   );

   rx_fifo #(.depth_log2(uart_reg_pkg::fifo_depth_log2)) fifo_i
   (
      .clk    (clk),
      .reset  (reset),
      .wr     (rx_valid),
      .w_data (rx_data),
      .rd     (fifo_rd),
      .r_data (fifo_head),
      .empty  (fifo_empty),
      .full   (fifo_full),
      .level  (fifo_level)
   );

   // Receiver count leads the FIFO counters during the rx_valid cycle
   a_counts_agree: assert property (@(posedge clk) disable iff (reset)
      (fifo_wr_count + fifo_full_count + 32'(rx_valid)) == char_count);

endmodule

`default_nettype wire

// File: uart_line_pkg.sv
`default_nettype none

package uart_line_pkg;

   // Frame is fixed 8N1
   localparam int data_bits = 8;
   localparam int cpb_width = 16;

   localparam logic [cpb_width-1:0] cpb_default = 16'd217;  // 25 MHz clock, 115200 baud

   // Line levels
   localparam logic line_idle = 1'b1;
   localparam logic start_bit = 1'b0;
   localparam logic stop_bit  = 1'b1;

   typedef enum logic [1:0] {
      tx_idle,
      tx_start,
      tx_data,
      tx_stop
   } tx_state_e;

   typedef enum logic [1:0] {
      rx_idle,
      rx_start,
      rx_data,
      rx_stop
   } rx_state_e;

endpackage

`default_nettype wire

// File: uart_reg_pkg.sv
`default_nettype none

package uart_reg_pkg;

   localparam int bus_width = 32;

   // Register map, four address bits
   typedef enum logic [3:0] {
      reg_dr              = 4'd0,  // Write sends, read peeks FIFO head
      reg_ctrl            = 4'd1,
      reg_rstat           = 4'd2,
      reg_tstat           = 4'd3,
      reg_cpb             = 4'd4,
      reg_queue           = 4'd5,  // Read pops FIFO head
      reg_char_count      = 4'd7,
      reg_fifo_wr_count   = 4'd8,
      reg_fifo_full_count = 4'd9,
      reg_scratch0        = 4'd12,
      reg_scratch1        = 4'd13,
      reg_scratch2        = 4'd14,
      reg_scratch3        = 4'd15
   } reg_addr_e;

   // Control register bits
   localparam int ctrl_rx_en = 0;
   localparam int ctrl_tx_en = 1;

   // RSTAT bits
   localparam int stat_rxne      = 0;
   localparam int stat_break     = 1;
   localparam int stat_full      = 2;
   localparam int stat_level_lsb = 4;

   // TSTAT bits
   localparam int stat_tc = 0;

   // Receive FIFO of 16 entries, level field is 5 bits wide
   localparam int fifo_depth_log2 = 4;

endpackage

`default_nettype wire

// File: uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx
(
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic [uart_line_pkg::cpb_width-1:0]  cpb,
   input  logic                                 rx_en,
   input  logic                                 rxd,
   output logic                                 rx_valid,
   output logic [uart_line_pkg::data_bits-1:0]  rx_data,
   output logic                                 rx_break,
   output logic [31:0]                          char_count
);

   uart_line_pkg::rx_state_e state;

   logic rxd_meta;
   logic rxd_sync;
   logic rxd_prev;   // For falling edge detection

   logic [uart_line_pkg::cpb_width-1:0]       bit_cnt;
   logic [$clog2(uart_line_pkg::data_bits)-1:0] bit_idx;
   logic [uart_line_pkg::data_bits-1:0]       shift;
   logic                                       start_edge;
   logic                                       half_done;
   logic                                       bit_done;
   logic                                       sample;
   logic                                       frame_end;

   // Two-flop synchronizer
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rxd_meta <= uart_line_pkg::line_idle;
         rxd_sync <= uart_line_pkg::line_idle;
         rxd_prev <= uart_line_pkg::line_idle;
      end
      else
      begin
         rxd_meta <= rxd;
         rxd_sync <= rxd_meta;
         rxd_prev <= rxd_sync;
      end
   end

   // A held-low line gives no new edge, so a long break is seen once
   assign start_edge = (rxd_prev == uart_line_pkg::line_idle) &&
                       (rxd_sync == uart_line_pkg::start_bit);
   assign half_done  = (bit_cnt == {1'b0, cpb[uart_line_pkg::cpb_width-1:1]});
   assign bit_done   = (bit_cnt == cpb - 1'b1);
   assign sample     = rx_en && (state == uart_line_pkg::rx_data) && bit_done;
   assign frame_end  = rx_en && (state == uart_line_pkg::rx_stop) && bit_done;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state      <= uart_line_pkg::rx_idle;
         bit_cnt    <= '0;
         bit_idx    <= '0;
         rx_valid   <= 1'b0;
         rx_break   <= 1'b0;
         char_count <= '0;
      end
      else
      begin
         rx_valid <= 1'b0;  // Single-cycle pulses
         rx_break <= 1'b0;
         bit_cnt  <= bit_cnt + 1'b1;
         if (!rx_en)
            state <= uart_line_pkg::rx_idle;
         else
         begin
            case (state)
               uart_line_pkg::rx_idle:
               begin
                  bit_cnt <= '0;
                  if (start_edge)
                     state <= uart_line_pkg::rx_start;
               end
               uart_line_pkg::rx_start:
               begin
                  if (half_done)
                  begin
                     bit_cnt <= '0;
                     bit_idx <= '0;
                     // Glitch check at mid start bit
                     if (rxd_sync == uart_line_pkg::start_bit)
                        state <= uart_line_pkg::rx_data;
                     else
                        state <= uart_line_pkg::rx_idle;
                  end
               end
               uart_line_pkg::rx_data:
               begin
                  if (bit_done)
                  begin
                     bit_cnt <= '0;
                     if (bit_idx == 3'(uart_line_pkg::data_bits - 1))
                        state <= uart_line_pkg::rx_stop;
                     else
                        bit_idx <= bit_idx + 1'b1;
                  end
               end
               default:
               begin
                  if (bit_done)
                  begin
                     state <= uart_line_pkg::rx_idle;
                     if (rxd_sync == uart_line_pkg::stop_bit)
                     begin
                        rx_valid   <= 1'b1;
                        char_count <= char_count + 1'b1;
                     end
                     else if (shift == '0)
                        rx_break <= 1'b1;   // Framing error with nonzero data is dropped
                  end
               end
            endcase
         end
      end
   end

   // Data path, LSB arrives first
   always_ff @(posedge clk)
   begin
      if (sample)
         shift <= {rxd_sync, shift[uart_line_pkg::data_bits-1:1]};
      if (frame_end && rxd_sync == uart_line_pkg::stop_bit)
         rx_data <= shift;
   end

   a_valid_break_excl: assert property (@(posedge clk) disable iff (reset)
      !(rx_valid && rx_break));

endmodule

`default_nettype wire

// File: uart_stim.txt
# op addr(hex) data(hex) expected(hex)
# W write, R read and compare, P poll until data bits set, B break cycles, N wait cycles
# Reset values
R 1 0 0
R 4 0 d9
R 3 0 1
R 2 0 0
R 7 0 0
R 8 0 0
R 9 0 0
# Register read back
W 4 1234 0
R 4 0 1234
W 4 8 0
R 4 0 8
W 1 3 0
R 1 0 3
W c deadbeef 0
W d 12345678 0
W e a5a5a5a5 0
W f 0000ffff 0
R c 0 deadbeef
R d 0 12345678
R e 0 a5a5a5a5
R f 0 0000ffff
R 6 0 0
R a 0 0
R b 0 0
# Loopback of three bytes
W 0 41 0
P 3 1 0
W 0 5a 0
P 3 1 0
W 0 c3 0
P 3 1 0
N 0 14 0
R 2 0 31
R 7 0 3
R 8 0 3
R 0 0 41
R 5 0 41
R 2 0 21
R 5 0 5a
R 2 0 11
R 5 0 c3
R 2 0 0
# Eighteen bytes into a sixteen entry FIFO
W 0 10 0
P 3 1 0
W 0 11 0
P 3 1 0
W 0 12 0
P 3 1 0
W 0 13 0
P 3 1 0
W 0 14 0
P 3 1 0
W 0 15 0
P 3 1 0
W 0 16 0
P 3 1 0
W 0 17 0
P 3 1 0
W 0 18 0
P 3 1 0
W 0 19 0
P 3 1 0
W 0 1a 0
P 3 1 0
W 0 1b 0
P 3 1 0
W 0 1c 0
P 3 1 0
W 0 1d 0
P 3 1 0
W 0 1e 0
P 3 1 0
W 0 1f 0
P 3 1 0
W 0 20 0
P 3 1 0
W 0 21 0
P 3 1 0
N 0 14 0
R 2 0 105
R 9 0 2
R 8 0 13
R 7 0 15
R 5 0 10
R 5 0 11
R 5 0 12
R 5 0 13
R 5 0 14
R 5 0 15
R 5 0 16
R 5 0 17
R 5 0 18
R 5 0 19
R 5 0 1a
R 5 0 1b
R 5 0 1c
R 5 0 1d
R 5 0 1e
R 5 0 1f
R 2 0 0
# Break longer than a frame
B 0 78 0
N 0 1e 0
R 2 0 2
R 7 0 15
R 8 0 13
W 2 0 0
R 2 0 0
# Transmitter disabled
W 1 1 0
R 1 0 1
W 0 55 0
R 3 0 1
N 0 64 0
R 3 0 1
R 2 0 0
R 7 0 15

// File: uart_tb.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tb;

   localparam int test_cpb     = 8;     // Divider used by the serial tests
   localparam int cycle_margin = 1000;

   logic                               clk;
   logic                               reset;
   logic                               cs;
   logic                               wen;
   logic [3:0]                         addr;
   logic [uart_reg_pkg::bus_width-1:0] din;
   logic [uart_reg_pkg::bus_width-1:0] dout;
   logic                               rxd;
   logic                               txd;
   logic                               break_on;

   // One entry per bus operation from the stimulus file
   logic [7:0]  op_q [$];
   logic [3:0]  addr_q [$];
   logic [31:0] data_q [$];
   logic [31:0] exp_q [$];

   int errors;
   int checks;
   int cycle_count;
   int cycle_limit;

   uart dut_i
   (
      .clk   (clk),
      .reset (reset),
      .cs    (cs),
      .wen   (wen),
      .addr  (addr),
      .din   (din),
      .dout  (dout),
      .rxd   (rxd),
      .txd   (txd)
   );

   assign rxd = break_on ? 1'b0 : txd;  // Loopback unless a break is forced

   always #50 clk = ~clk;

   // Run limit
   always @(posedge clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= cycle_limit)
      begin
         $display("Timeout: stimulus did not finish within %0d cycles", cycle_limit);
         $display("Checks run: %0d, errors: %0d", checks, errors);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   task automatic load_stim();
      int          fd;
      int          rc;
      int          ch;
      logic [7:0]  op;
      logic [31:0] a;
      logic [31:0] d;
      logic [31:0] e;
      fd = $fopen("uart_stim.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open the stimulus file uart_stim.txt");
         errors++;
         return;
      end
      while (!$feof(fd))
      begin
         rc = $fscanf(fd, " %c", op);
         if (rc != 1)
            break;
         if (op == "#")
         begin
            ch = 0;
            while (ch != 10 && ch != -1)
               ch = $fgetc(fd);  // Skip comment line
         end
         else
         begin
            rc = $fscanf(fd, "%h %h %h", a, d, e);
            if (rc != 3)
            begin
               $display("Stimulus file is malformed after operation %0d", op_q.size());
               errors++;
               break;
            end
            op_q.push_back(op);
            addr_q.push_back(a[3:0]);
            data_q.push_back(d);
            exp_q.push_back(e);
         end
      end
      $fclose(fd);
   endtask

   task automatic write_reg(input logic [3:0] a, input logic [31:0] d);
      cs   = 1'b1;
      wen  = 1'b1;
      addr = a;
      din  = d;
      @(posedge clk);
      #5;
      cs  = 1'b0;
      wen = 1'b0;
   endtask

   // dout is combinational, sampled mid-cycle
   task automatic read_reg(input logic [3:0] a, output logic [31:0] val);
      cs   = 1'b1;
      wen  = 1'b0;
      addr = a;
      @(negedge clk);
      val = dout;
      @(posedge clk);  // Queue pop happens here
      #5;
      cs = 1'b0;
   endtask

   task automatic poll_bits(input logic [3:0] a, input logic [31:0] mask);
      logic [31:0] val;
      val = '0;
      while ((val & mask) != mask)
         read_reg(a, val);
   endtask

   task automatic force_break(input int cycles);
      break_on = 1'b1;
      repeat (cycles) @(posedge clk);
      #5;
      break_on = 1'b0;
   endtask

   task automatic wait_cycles(input int cycles);
      repeat (cycles) @(posedge clk);
      #5;
   endtask

   task automatic run_op(input int i);
      logic [31:0] val;
      case (op_q[i])
         "W": write_reg(addr_q[i], data_q[i]);
         "R":
         begin
            read_reg(addr_q[i], val);
            checks++;
            assert (val === exp_q[i])
            else
            begin
               $display("ERROR at %0t ns: op %0d read addr %h gave %h, expected %h",
                        $time, i, addr_q[i], val, exp_q[i]);
               errors++;
            end
         end
         "P": poll_bits(addr_q[i], data_q[i]);
         "B": force_break(data_q[i]);
         "N": wait_cycles(data_q[i]);
         default:
         begin
            $display("Unknown operation %c in stimulus operation %0d", op_q[i], i);
            errors++;
         end
      endcase
   endtask

   initial
   begin
      clk         = 1'b0;
      reset       = 1'b1;
      cs          = 1'b0;
      wen         = 1'b0;
      addr        = '0;
      din         = '0;
      break_on    = 1'b0;
      errors      = 0;
      checks      = 0;
      cycle_count = 0;
      cycle_limit = cycle_margin;
      load_stim();
      // About a frame and a bit per operation at the test divider
      cycle_limit = op_q.size() * 12 * test_cpb + cycle_margin;
      repeat (3) @(posedge clk);
      #5;
      reset = 1'b0;
      foreach (op_q[i])
         run_op(i);
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire

// File: uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx
(
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic [uart_line_pkg::cpb_width-1:0]  cpb,
   input  logic                                 tx_valid,
   input  logic [uart_line_pkg::data_bits-1:0]  tx_data,
   output logic                                 tx_ready,
   output logic                                 txd
);

   uart_line_pkg::tx_state_e state;

   logic [uart_line_pkg::cpb_width-1:0]       bit_cnt;
   logic [$clog2(uart_line_pkg::data_bits)-1:0] bit_idx;
   logic [uart_line_pkg::data_bits-1:0]       shift;
   logic                                       bit_done;
   logic                                       accept;
   logic                                       line_bit;

   assign accept   = tx_valid && tx_ready;
   assign bit_done = (bit_cnt == cpb - 1'b1);

   // Level the line should carry for the current state
   always_comb
   begin
      case (state)
         uart_line_pkg::tx_start: line_bit = uart_line_pkg::start_bit;
         uart_line_pkg::tx_data:  line_bit = shift[0];
         uart_line_pkg::tx_stop:  line_bit = uart_line_pkg::stop_bit;
         default:                 line_bit = uart_line_pkg::line_idle;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= uart_line_pkg::tx_idle;
         tx_ready <= 1'b1;
         txd      <= uart_line_pkg::line_idle;
         bit_cnt  <= '0;
         bit_idx  <= '0;
      end
      else
      begin
         txd <= line_bit;  // Line lags the state by one cycle
         case (state)
            uart_line_pkg::tx_idle:
            begin
               bit_cnt <= '0;
               bit_idx <= '0;
               if (accept)
               begin
                  state    <= uart_line_pkg::tx_start;
                  tx_ready <= 1'b0;
               end
               else
                  tx_ready <= 1'b1;  // Rises one cycle after the stop bit state ends
            end
            uart_line_pkg::tx_start:
            begin
               bit_cnt <= bit_done ? '0 : bit_cnt + 1'b1;
               if (bit_done)
                  state <= uart_line_pkg::tx_data;
            end
            uart_line_pkg::tx_data:
            begin
               bit_cnt <= bit_done ? '0 : bit_cnt + 1'b1;
               if (bit_done)
               begin
                  if (bit_idx == 3'(uart_line_pkg::data_bits - 1))
                     state <= uart_line_pkg::tx_stop;
                  else
                     bit_idx <= bit_idx + 1'b1;
               end
            end
            default:
            begin
               bit_cnt <= bit_done ? '0 : bit_cnt + 1'b1;
               if (bit_done)
                  state <= uart_line_pkg::tx_idle;
            end
         endcase
      end
   end

   // Data shifter, LSB goes out first
   always_ff @(posedge clk)
   begin
      if (accept)
         shift <= tx_data;
      else if (state == uart_line_pkg::tx_data && bit_done)
         shift <= shift >> 1;
   end

   // A busy transmitter must never offer ready
   a_ready_only_idle: assert property (@(posedge clk) disable iff (reset)
      (state != uart_line_pkg::tx_idle) |-> !tx_ready);

endmodule

`default_nettype wire
